// File: src/rv32_isa_pkg.sv
/* RV32I instruction-set types: data word, register index, instruction word,
   major opcode and ALU operation encodings */
`default_nettype none

package rv32_isa_pkg;

    // --------------------
    // basic widths
    // --------------------

    // data and address word
    typedef logic [31:0] word_t;

    // architectural register index, x0..x31
    typedef logic [4:0] reg_idx_t;

    // raw instruction word as fetched
    typedef logic [31:0] instr_t;

    // --------------------
    // encodings
    // --------------------

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_e;

    // ALU operation, PASS_B forwards operand b unchanged (LUI)
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLT    = 4'd5,
        SLTU   = 4'd6,
        PASS_B = 4'd7
    } alu_op_e;

endpackage

`default_nettype wire

// File: src/core_pipe_pkg.sv
/* pipeline-stage packets for fetch, decode and result, plus the operand
   forwarding select */
`default_nettype none

package core_pipe_pkg;

    import rv32_isa_pkg::*;

    // --------------------
    // stage packets
    // --------------------

    // fetched word with its address
    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_t instr;
    } fetch_pkt_t;

    // decoded instruction with register values read in decode
    typedef struct packed {
        logic     valid;
        alu_op_e  alu_op;
        reg_idx_t rd;
        logic     we;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     b_is_imm;
        word_t    imm;
        word_t    a;
        word_t    b;
    } decode_pkt_t;

    // execute result, also the register file write port
    typedef struct packed {
        logic     valid;
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } result_pkt_t;

    // where execute takes an operand from
    typedef enum logic [1:0] {
        REGFILE     = 2'd0,
        FROM_EXEC   = 2'd1,
        FROM_RESULT = 2'd2
    } fwd_sel_e;

endpackage

`default_nettype wire

// File: src/instr_fetch.sv
/* instruction fetch: program counter, request/grant bus FSM and the
   registered fetch packet */
`timescale 1ns/100ps
`default_nettype none

module instr_fetch #(
    parameter rv32_isa_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       instr_gnt,
    input  wire rv32_isa_pkg::word_t        instr_data,
    output logic                            instr_req,
    output rv32_isa_pkg::word_t             instr_addr,
    output core_pipe_pkg::fetch_pkt_t       fetch
);

    import rv32_isa_pkg::*;
    import core_pipe_pkg::*;

    typedef enum logic {
        IDLE,
        WAIT_GNT
    } fetch_state_e;

    fetch_state_e state;
    word_t        pc;
    logic         grant;

    // --------------------
    // request FSM
    // --------------------

    // one idle cycle after reset, then a request is always pending
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            pc    <= reset_pc;
        end else begin
            case (state)
                IDLE:     state <= WAIT_GNT;
                WAIT_GNT: state <= WAIT_GNT;
                default:  state <= IDLE;
            endcase
            if (grant) begin
                pc <= pc + 32'd4;
            end
        end
    end

    assign instr_req  = (state == WAIT_GNT);
    assign instr_addr = pc;
    assign grant      = instr_req & instr_gnt;

    // --------------------
    // fetch packet
    // --------------------

    // data is only valid in the grant cycle, so capture it there
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch.valid <= 1'b0;
        end else begin
            fetch.valid <= grant;
        end
        if (grant) begin
            fetch.pc    <= pc;
            fetch.instr <= instr_data;
        end
    end

endmodule

`default_nettype wire

// File: src/instr_decode.sv
/* instruction decode: field split, ALU op mapping, immediates and the
   32-entry register file with write-through read */
`timescale 1ns/100ps
`default_nettype none

module instr_decode (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire core_pipe_pkg::fetch_pkt_t   fetch,
    input  wire core_pipe_pkg::result_pkt_t  result,
    output core_pipe_pkg::decode_pkt_t       decode,
    output rv32_isa_pkg::reg_idx_t           rs1,
    output rv32_isa_pkg::reg_idx_t           rs2
);

    import rv32_isa_pkg::*;
    import core_pipe_pkg::*;

    instr_t   instr;
    reg_idx_t rd;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_e  alu_op;
    logic     known;
    logic     b_is_imm;
    word_t    imm;
    word_t    rdata_a;
    word_t    rdata_b;
    logic     wr_en;

    // x1..x31 only, x0 is hardwired
    word_t regs [1:31];

    // --------------------
    // field split
    // --------------------

    assign instr  = fetch.instr;
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    always_comb begin
        alu_op   = ADD;
        known    = 1'b0;
        b_is_imm = 1'b0;
        imm      = {{20{instr[31]}}, instr[31:20]};
        case (opcode_e'(instr[6:0]))
            OP: begin
                known = (funct7 == 7'b0000000);
                case (funct3)
                    3'b000: begin
                        if (funct7 == 7'b0100000) begin
                            alu_op = SUB;
                            known  = 1'b1;
                        end
                    end
                    3'b111:  alu_op = AND;
                    3'b110:  alu_op = OR;
                    3'b100:  alu_op = XOR;
                    3'b010:  alu_op = SLT;
                    3'b011:  alu_op = SLTU;
                    // shifts are not supported
                    default: known = 1'b0;
                endcase
            end
            OP_IMM: begin
                b_is_imm = 1'b1;
                known    = 1'b1;
                case (funct3)
                    3'b000:  alu_op = ADD;
                    3'b111:  alu_op = AND;
                    3'b110:  alu_op = OR;
                    3'b100:  alu_op = XOR;
                    3'b010:  alu_op = SLT;
                    default: known = 1'b0;
                endcase
            end
            LUI: begin
                alu_op   = PASS_B;
                b_is_imm = 1'b1;
                known    = 1'b1;
                imm      = {instr[31:12], 12'b0};
            end
            default: known = 1'b0;
        endcase
    end

    // --------------------
    // register file
    // --------------------

    assign wr_en = result.valid & result.we & (result.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[result.rd] <= result.data;
        end
    end

    // same-cycle write is visible to the read
    always_comb begin
        if (rs1 == 5'd0)                    rdata_a = '0;
        else if (wr_en && result.rd == rs1) rdata_a = result.data;
        else                                rdata_a = regs[rs1];
        if (rs2 == 5'd0)                    rdata_b = '0;
        else if (wr_en && result.rd == rs2) rdata_b = result.data;
        else                                rdata_b = regs[rs2];
    end

    // decode register
    always_ff @(posedge clk) begin
        if (reset) begin
            decode.valid <= 1'b0;
            decode.we    <= 1'b0;
        end else begin
            decode.valid <= fetch.valid;
            decode.we    <= fetch.valid & known & (rd != 5'd0);
        end
        decode.alu_op   <= alu_op;
        decode.rd       <= rd;
        decode.rs1      <= rs1;
        decode.rs2      <= rs2;
        decode.b_is_imm <= b_is_imm;
        decode.imm      <= imm;
        decode.a        <= rdata_a;
        decode.b        <= rdata_b;
    end

endmodule

`default_nettype wire

// File: src/hazard_ctrl.sv
/* hazard control: matches decode sources against in-flight writers and
   picks the operand forwarding source */
`timescale 1ns/100ps
`default_nettype none

module hazard_ctrl (
    input  wire rv32_isa_pkg::reg_idx_t      rs1,
    input  wire rv32_isa_pkg::reg_idx_t      rs2,
    input  wire core_pipe_pkg::decode_pkt_t  decode,
    input  wire core_pipe_pkg::result_pkt_t  result,
    output core_pipe_pkg::fwd_sel_e          fwd_a,
    output core_pipe_pkg::fwd_sel_e          fwd_b
);

    import rv32_isa_pkg::*;
    import core_pipe_pkg::*;

    logic exec_hit_a;
    logic exec_hit_b;
    logic res_hit_a;
    logic res_hit_b;

    // --------------------
    // writer matches
    // --------------------

    // instruction now in execute sits in the result register next cycle
    assign exec_hit_a = decode.valid & decode.we & (rs1 != 5'd0) & (decode.rd == rs1);
    assign exec_hit_b = decode.valid & decode.we & (rs2 != 5'd0) & (decode.rd == rs2);

    // instruction being written back this cycle
    assign res_hit_a = result.valid & result.we & (rs1 != 5'd0) & (result.rd == rs1);
    assign res_hit_b = result.valid & result.we & (rs2 != 5'd0) & (result.rd == rs2);

    // youngest writer wins
    always_comb begin
        if (exec_hit_a)     fwd_a = FROM_EXEC;
        else if (res_hit_a) fwd_a = FROM_RESULT;
        else                fwd_a = REGFILE;

        if (exec_hit_b)     fwd_b = FROM_EXEC;
        else if (res_hit_b) fwd_b = FROM_RESULT;
        else                fwd_b = REGFILE;
    end

endmodule

`default_nettype wire

// File: src/alu_execute.sv
/* execute stage: forwarding muxes, ALU and the result register */
`timescale 1ns/100ps
`default_nettype none

module alu_execute (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire core_pipe_pkg::decode_pkt_t  decode,
    input  wire core_pipe_pkg::fwd_sel_e     fwd_a,
    input  wire core_pipe_pkg::fwd_sel_e     fwd_b,
    output core_pipe_pkg::result_pkt_t       result
);

    import rv32_isa_pkg::*;
    import core_pipe_pkg::*;

    fwd_sel_e sel_a;
    fwd_sel_e sel_b;
    word_t    last_data;
    word_t    op_a;
    word_t    op_b;
    word_t    reg_b;
    word_t    alu_out;

    // selects computed in decode, held to line up with this stage
    always_ff @(posedge clk) begin
        if (reset) begin
            sel_a <= REGFILE;
            sel_b <= REGFILE;
        end else begin
            sel_a <= fwd_a;
            sel_b <= fwd_b;
        end
        // word written back while the current instruction was in decode
        last_data <= result.data;
    end

    // --------------------
    // operand muxes
    // --------------------

    always_comb begin
        case (sel_a)
            FROM_EXEC:   op_a = result.data;
            FROM_RESULT: op_a = last_data;
            default:     op_a = decode.a;
        endcase
        case (sel_b)
            FROM_EXEC:   reg_b = result.data;
            FROM_RESULT: reg_b = last_data;
            default:     reg_b = decode.b;
        endcase
        op_b = decode.b_is_imm ? decode.imm : reg_b;
    end

    // ALU
    always_comb begin
        case (decode.alu_op)
            ADD:     alu_out = op_a + op_b;
            SUB:     alu_out = op_a - op_b;
            AND:     alu_out = op_a & op_b;
            OR:      alu_out = op_a | op_b;
            XOR:     alu_out = op_a ^ op_b;
            SLT:     alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            SLTU:    alu_out = {31'b0, op_a < op_b};
            PASS_B:  alu_out = op_b;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result.valid <= 1'b0;
            result.we    <= 1'b0;
        end else begin
            result.valid <= decode.valid;
            result.we    <= decode.valid & decode.we;
        end
        result.rd   <= decode.rd;
        result.data <= alu_out;
    end

endmodule

`default_nettype wire

// File: src/rv_core_top.sv
/* core top level: fetch, decode, execute and hazard control */
`timescale 1ns/100ps
`default_nettype none

module rv_core_top #(
    parameter rv32_isa_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    instr_gnt,
    input  wire rv32_isa_pkg::word_t     instr_data,
    output logic                         instr_req,
    output rv32_isa_pkg::word_t          instr_addr,
    output logic                         wb_valid,
    output rv32_isa_pkg::reg_idx_t       wb_rd,
    output rv32_isa_pkg::word_t          wb_data
);

    import rv32_isa_pkg::*;
    import core_pipe_pkg::*;

    fetch_pkt_t  fetch;
    decode_pkt_t decode;
    result_pkt_t result;
    fwd_sel_e    fwd_a;
    fwd_sel_e    fwd_b;
    reg_idx_t    rs1;
    reg_idx_t    rs2;

    instr_fetch #(
        .reset_pc(reset_pc)
    ) u_fetch (
        .clk       (clk),
        .reset     (reset),
        .instr_gnt (instr_gnt),
        .instr_data(instr_data),
        .instr_req (instr_req),
        .instr_addr(instr_addr),
        .fetch     (fetch)
    );

    instr_decode u_decode (
        .clk   (clk),
        .reset (reset),
        .fetch (fetch),
        .result(result),
        .decode(decode),
        .rs1   (rs1),
        .rs2   (rs2)
    );

    hazard_ctrl u_hazard (
        .rs1   (rs1),
        .rs2   (rs2),
        .decode(decode),
        .result(result),
        .fwd_a (fwd_a),
        .fwd_b (fwd_b)
    );

    alu_execute u_execute (
        .clk   (clk),
        .reset (reset),
        .decode(decode),
        .fwd_a (fwd_a),
        .fwd_b (fwd_b),
        .result(result)
    );

    // retirement port, only writing instructions retire
    assign wb_valid = result.valid & result.we;
    assign wb_rd    = result.rd;
    assign wb_data  = result.data;

endmodule

`default_nettype wire

// File: test/imem_model.sv
/* instruction memory model for the fetch bus, granting each request after
   a random delay of 0 to max_delay cycles */
`timescale 1ns/100ps
`default_nettype none

module imem_model #(
    parameter int depth = 64
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 req,
    input  wire rv32_isa_pkg::word_t  addr,
    input  wire logic [1:0]           max_delay,
    output logic                      gnt,
    output rv32_isa_pkg::word_t       data
);

    import rv32_isa_pkg::*;

    localparam int index_bits = $clog2(depth);

    word_t       mem [0:depth-1];
    logic        in_reset;
    logic        pending;
    int unsigned wait_left;

    initial begin
        gnt       = 1'b0;
        pending   = 1'b0;
        wait_left = 0;
    end

    // word at the requested address, held while req is high
    assign data = mem[addr[index_bits+1:2]];

    // --------------------
    // grant timing
    // --------------------

    // reset is taken at the edge, req once the core has updated it
    always @(posedge clk) begin
        in_reset = reset;
        #1;
        if (in_reset || !req) begin
            gnt     = 1'b0;
            pending = 1'b0;
        end else if (gnt || !pending) begin
            // a new request starts here
            wait_left = $urandom_range(32'(max_delay));
            pending   = 1'b1;
            gnt       = (wait_left == 0);
        end else begin
            wait_left = wait_left - 1;
            gnt       = (wait_left == 0);
        end
    end

endmodule

`default_nettype wire

// File: test/tb_rv_core.sv
/* testbench for the RV32I core: clock, reset, program table with expected
   retirements, fetch address and retirement checks, watchdog */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    import rv32_isa_pkg::*;

    localparam word_t reset_pc        = 32'h0000_0100;
    localparam int    mem_words       = 64;
    localparam int    max_grant_delay = 3;
    localparam int    drain_cycles    = 12;
    localparam int    cut_retirements = 4;
    localparam int    n_passes        = 3;

    localparam logic [6:0] f7_base = 7'h00;
    localparam logic [6:0] f7_sub  = 7'h20;
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // one program row, rd of zero means the row never retires
    typedef struct packed {
        instr_t   instr;
        reg_idx_t rd;
        word_t    value;
    } row_t;

    logic       clk;
    logic       reset;
    logic       reset_seen    = 1'b1;
    logic       program_ready = 1'b0;
    logic [1:0] max_delay;
    logic       instr_req;
    logic       instr_gnt;
    word_t      instr_addr;
    word_t      instr_data;
    logic       wb_valid;
    reg_idx_t   wb_rd;
    word_t      wb_data;

    row_t  rows [$];
    int    n_expect;
    int    exp_idx;
    int    retired;
    int    pass_no;
    word_t exp_addr;
    int    value_errors;
    int    flow_errors;

    rv_core_top #(
        .reset_pc(reset_pc)
    ) dut0 (
        .clk       (clk),
        .reset     (reset),
        .instr_gnt (instr_gnt),
        .instr_data(instr_data),
        .instr_req (instr_req),
        .instr_addr(instr_addr),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    imem_model #(
        .depth(mem_words)
    ) imem0 (
        .clk      (clk),
        .reset    (reset),
        .req      (instr_req),
        .addr     (instr_addr),
        .max_delay(max_delay),
        .gnt      (instr_gnt),
        .data     (instr_data)
    );

    always #4 clk = ~clk;

    // high once the core has seen reset at an edge
    always @(posedge clk) reset_seen <= reset;

    // --------------------
    // instruction encoders
    // --------------------

    function automatic instr_t r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                      input reg_idx_t rd, input reg_idx_t rs1,
                                      input reg_idx_t rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic instr_t i_type(input logic [2:0] funct3, input reg_idx_t rd,
                                      input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, funct3, rd, 7'b0010011};
    endfunction

    function automatic instr_t u_type(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // load opcode, so fill words never retire
    function automatic instr_t fill_word(input int index);
        return {index[24:0], 7'b0000011};
    endfunction

    task automatic add_row(input instr_t instr, input reg_idx_t rd, input word_t value);
        row_t row;
        row.instr = instr;
        row.rd    = rd;
        row.value = value;
        rows.push_back(row);
    endtask

    task automatic build_program();
        // doubler chain
        add_row(i_type(f3_add, 5'd1, 5'd0, 12'd2), 5'd1, 32'd2);
        add_row(r_type(f7_base, f3_add, 5'd1, 5'd1, 5'd1), 5'd1, 32'd4);
        add_row(r_type(f7_base, f3_add, 5'd1, 5'd1, 5'd1), 5'd1, 32'd8);
        add_row(r_type(f7_base, f3_add, 5'd1, 5'd1, 5'd1), 5'd1, 32'd16);
        add_row(r_type(f7_base, f3_add, 5'd1, 5'd1, 5'd1), 5'd1, 32'd32);
        // fibonacci over x2 and x3
        add_row(i_type(f3_add, 5'd2, 5'd0, 12'd1), 5'd2, 32'd1);
        add_row(i_type(f3_add, 5'd3, 5'd0, 12'd1), 5'd3, 32'd1);
        add_row(r_type(f7_base, f3_add, 5'd2, 5'd2, 5'd3), 5'd2, 32'd2);
        add_row(r_type(f7_base, f3_add, 5'd3, 5'd2, 5'd3), 5'd3, 32'd3);
        add_row(r_type(f7_base, f3_add, 5'd2, 5'd2, 5'd3), 5'd2, 32'd5);
        add_row(r_type(f7_base, f3_add, 5'd3, 5'd2, 5'd3), 5'd3, 32'd8);
        add_row(r_type(f7_base, f3_add, 5'd2, 5'd2, 5'd3), 5'd2, 32'd13);
        add_row(r_type(f7_base, f3_add, 5'd3, 5'd2, 5'd3), 5'd3, 32'd21);
        // ALU ops with x4 = -5 and x5 = 7
        add_row(i_type(f3_add, 5'd4, 5'd0, 12'hffb), 5'd4, 32'hffff_fffb);
        add_row(i_type(f3_add, 5'd5, 5'd0, 12'd7), 5'd5, 32'd7);
        add_row(r_type(f7_sub, f3_add, 5'd6, 5'd5, 5'd4), 5'd6, 32'd12);
        add_row(r_type(f7_base, f3_and, 5'd7, 5'd4, 5'd5), 5'd7, 32'd3);
        add_row(r_type(f7_base, f3_or, 5'd8, 5'd4, 5'd5), 5'd8, 32'hffff_ffff);
        add_row(r_type(f7_base, f3_xor, 5'd9, 5'd4, 5'd5), 5'd9, 32'hffff_fffc);
        add_row(r_type(f7_base, f3_slt, 5'd10, 5'd4, 5'd5), 5'd10, 32'd1);
        add_row(r_type(f7_base, f3_sltu, 5'd11, 5'd4, 5'd5), 5'd11, 32'd0);
        add_row(i_type(f3_slt, 5'd12, 5'd4, 12'hffc), 5'd12, 32'd1);
        add_row(i_type(f3_and, 5'd13, 5'd5, 12'hffe), 5'd13, 32'd6);
        add_row(i_type(f3_or, 5'd14, 5'd5, 12'h7f0), 5'd14, 32'h0000_07f7);
        add_row(i_type(f3_xor, 5'd15, 5'd4, 12'hfff), 5'd15, 32'd4);
        add_row(u_type(5'd16, 20'h12345), 5'd16, 32'h1234_5000);
        add_row(i_type(f3_add, 5'd16, 5'd16, 12'h678), 5'd16, 32'h1234_5678);
        add_row(r_type(f7_base, f3_sltu, 5'd17, 5'd5, 5'd4), 5'd17, 32'd1);
        add_row(r_type(f7_base, f3_slt, 5'd18, 5'd5, 5'd4), 5'd18, 32'd0);
        // x0 writes, a load and a shift retire nothing
        add_row(i_type(f3_add, 5'd0, 5'd0, 12'd5), 5'd0, 32'd0);
        add_row(r_type(f7_base, f3_add, 5'd0, 5'd1, 5'd2), 5'd0, 32'd0);
        add_row({12'h000, 5'd0, 3'b010, 5'd19, 7'b0000011}, 5'd0, 32'd0);
        add_row(i_type(f3_sll, 5'd20, 5'd1, 12'd1), 5'd0, 32'd0);
        add_row(r_type(f7_base, f3_add, 5'd21, 5'd0, 5'd16), 5'd21, 32'h1234_5678);
        add_row(r_type(f7_base, f3_or, 5'd22, 5'd0, 5'd0), 5'd22, 32'd0);
        add_row(r_type(f7_sub, f3_add, 5'd23, 5'd3, 5'd1), 5'd23, 32'hffff_fff5);
        n_expect = 0;
        foreach (rows[i]) begin
            if (rows[i].rd != 5'd0) n_expect++;
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < mem_words; i++) begin
            imem0.mem[i] = (i < rows.size()) ? rows[i].instr : fill_word(i);
        end
    endtask

    // --------------------
    // compare tasks
    // --------------------

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Fail at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_rd(input string name, input reg_idx_t expected,
                            input reg_idx_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // match one retirement against the next row that writes a register
    task automatic score_retirement();
        while (exp_idx < rows.size() && rows[exp_idx].rd == 5'd0) exp_idx++;
        if (exp_idx >= rows.size()) begin
            flow_errors++;
            $display("extra retirement at %0t in pass %0d: x%0d written with %h",
                     $time, pass_no, wb_rd, wb_data);
        end else begin
            check_rd("wb_rd", rows[exp_idx].rd, wb_rd);
            check_word("wb_data", rows[exp_idx].value, wb_data);
            exp_idx++;
            retired++;
        end
    endtask

    // outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (reset_seen) begin
            check_bit("instr_req", 1'b0, instr_req);
            check_bit("wb_valid", 1'b0, wb_valid);
        end else begin
            if (instr_req && instr_gnt) begin
                check_word("instr_addr", exp_addr, instr_addr);
                exp_addr = exp_addr + 32'd4;
            end
            if (wb_valid) score_retirement();
        end
    end

    // a pass that stops short leaves writers in flight for the next reset
    task automatic run_pass(input int pass_index, input logic [1:0] delay,
                            input int stop_after);
        if (!reset) begin
            @(posedge clk);
            #1;
            reset = 1'b1;
        end
        repeat (3) @(posedge clk);
        // core is held in reset, restart the scoreboard
        pass_no   = pass_index;
        max_delay = delay;
        exp_idx   = 0;
        retired   = 0;
        exp_addr  = reset_pc;
        #1;
        reset = 1'b0;
        wait (retired == stop_after);
        if (stop_after == n_expect) begin
            repeat (drain_cycles) @(posedge clk);
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        max_delay    = 2'd0;
        value_errors = 0;
        flow_errors  = 0;
        pass_no      = 0;
        exp_idx      = 0;
        retired      = 0;
        exp_addr     = reset_pc;
        void'($urandom(32'hea96_22cf));
        build_program();
        load_program();
        program_ready = 1'b1;
        // back-to-back grants, a pass cut by reset, then slow random grants
        run_pass(0, 2'd0, n_expect);
        run_pass(1, 2'd0, cut_retirements);
        run_pass(2, 2'(max_grant_delay), n_expect);
        $display("checks done: %0d value errors, %0d retirement errors",
                 value_errors, flow_errors);
        if (value_errors == 0 && flow_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog over all passes
    initial begin
        int timeout_ns;
        wait (program_ready);
        timeout_ns = n_passes * (rows.size() * (4 + max_grant_delay) * 8 + 200);
        #(timeout_ns);
        $display("timeout: only %0d of %0d retirements seen in pass %0d",
                 retired, n_expect, pass_no);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
src/rv32_isa_pkg.sv
src/core_pipe_pkg.sv
src/instr_fetch.sv
src/instr_decode.sv
src/hazard_ctrl.sv
src/alu_execute.sv
src/rv_core_top.sv
test/imem_model.sv
test/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_rv_core -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_rv_core)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
    exit 0
fi
echo "simulation did not pass"
exit 1
